//--- src/pcap_cfg_pkg.sv
// Width and depth constants for the capture path
// Shared by the ingress FIFO, the record packer and the narrowing FIFO
package pcap_cfg_pkg;

  // AXI4-Stream ingress bus
  localparam int axis_data_w  = 64;
  // Descriptor must fit in one data beat
  localparam int axis_tuser_w = 64;
  localparam int axis_strb_w  = axis_data_w / 8;

  // Nine bits per byte, strobe above data
  localparam int rec_w          = axis_strb_w * 9;
  localparam int slice_w        = 18;
  localparam int slices_per_rec = rec_w / slice_w;
  localparam int slice_idx_w    = $clog2(slices_per_rec);
  localparam int slice_last_i   = slices_per_rec - 1;
  localparam logic [slice_idx_w-1:0] slice_last = slice_last_i[slice_idx_w-1:0];

  // Ingress beat FIFO, power of two deep
  localparam int ififo_depth_bits = 2;
  localparam int ififo_depth      = 1 << ififo_depth_bits;
  localparam int ififo_cnt_w      = ififo_depth_bits + 1;
  localparam int ififo_nf_lvl     = ififo_depth - 1;
  localparam logic [ififo_cnt_w-1:0] ififo_full_cnt = ififo_depth[ififo_cnt_w-1:0];
  localparam logic [ififo_cnt_w-1:0] ififo_nf_cnt   = ififo_nf_lvl[ififo_cnt_w-1:0];

  // Record FIFO, in 72-bit words
  localparam int rfifo_depth = 8;
  localparam int rfifo_ptr_w = $clog2(rfifo_depth);
  localparam int rfifo_cnt_w = rfifo_ptr_w + 1;
  localparam logic [rfifo_cnt_w-1:0] rfifo_full_cnt = rfifo_depth[rfifo_cnt_w-1:0];

endpackage

//--- src/pcap_rec_pkg.sv
// Types for ingress beats, record words and the packer FSM
// Widths come from the config package
package pcap_rec_pkg;

  // Plain bus vectors
  typedef logic [pcap_cfg_pkg::axis_data_w-1:0]  axis_data_t;
  typedef logic [pcap_cfg_pkg::axis_strb_w-1:0]  axis_strb_t;
  typedef logic [pcap_cfg_pkg::axis_tuser_w-1:0] axis_tuser_t;

  // One record word and one consumer slice
  typedef logic [pcap_cfg_pkg::rec_w-1:0]   rec_word_t;
  typedef logic [pcap_cfg_pkg::slice_w-1:0] fifo_slice_t;

  // Ingress beat as held in the small FIFO
  // Field order is last, tuser, strb, data from the top bit down
  typedef struct packed {
    logic        last;
    axis_tuser_t tuser;
    axis_strb_t  strb;
    axis_data_t  data;
  } axis_beat_t;

  // One byte lane of a record word, strobe as ninth bit
  typedef struct packed {
    logic       strb;
    logic [7:0] data;
  } rec_lane_t;

  // Packer FSM
  typedef enum logic {
    wr_tuser = 1'b0,
    wr_pkt   = 1'b1
  } pack_state_t;

endpackage

//--- src/fallthrough_small_fifo.sv
// Small first-word-fall-through FIFO for ingress beats
// Head entry is always on dout and rd_en consumes it
// nearly_full drives AXI-Stream back-pressure with one slot of margin
`timescale 1ns/1ps

module fallthrough_small_fifo (
  input  logic                     axi_aclk,
  input  logic                     rst_n,
  input  logic                     sw_rst,
  input  pcap_rec_pkg::axis_beat_t din,
  input  logic                     wr_en,
  input  logic                     rd_en,
  output pcap_rec_pkg::axis_beat_t dout,
  output logic                     empty,
  output logic                     nearly_full
);

  // Beat storage
  pcap_rec_pkg::axis_beat_t mem [pcap_cfg_pkg::ififo_depth];

  logic [pcap_cfg_pkg::ififo_depth_bits-1:0] wr_ptr;
  logic [pcap_cfg_pkg::ififo_depth_bits-1:0] rd_ptr;
  logic [pcap_cfg_pkg::ififo_cnt_w-1:0]      count;
  logic                                      full;
  logic                                      do_wr;
  logic                                      do_rd;

  assign full        = (count == pcap_cfg_pkg::ififo_full_cnt);
  assign empty       = (count == '0);
  // At most one free slot left
  assign nearly_full = (count >= pcap_cfg_pkg::ififo_nf_cnt);

  // Illegal requests are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Fall-through view of the head
  assign dout = mem[rd_ptr];

  always_ff @(posedge axi_aclk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge axi_aclk) begin
    if (!rst_n || sw_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // tready upstream must keep writes off a full FIFO
  a_no_wr_full: assert property (@(posedge axi_aclk) disable iff (!rst_n || sw_rst)
    wr_en |-> !full);

  // Packer must only pop what it sees
  a_no_rd_empty: assert property (@(posedge axi_aclk) disable iff (!rst_n || sw_rst)
    rd_en |-> !empty);

endmodule

//--- src/pcap_record_packer.sv
// Packet record packer between the ingress FIFO and the record FIFO
// Per packet emits one descriptor word, then one word per data beat
// Each byte leaves as {strobe, data} in a nine-bit lane
`timescale 1ns/1ps

module pcap_record_packer (
  input  logic                     axi_aclk,
  input  logic                     rst_n,
  input  logic                     sw_rst,
  input  pcap_rec_pkg::axis_beat_t beat,
  input  logic                     beat_empty,
  output logic                     beat_rd_en,
  input  logic                     rec_full,
  output pcap_rec_pkg::rec_word_t  rec_din,
  output logic                     rec_wr_en
);

  pcap_rec_pkg::pack_state_t state;
  pcap_rec_pkg::pack_state_t next_state;

  // Lane sources from descriptor or beat
  pcap_rec_pkg::axis_data_t src_data;
  pcap_rec_pkg::axis_strb_t src_strb;

  // Packed lanes with lane 0 in the low nine bits
  pcap_rec_pkg::rec_lane_t [pcap_cfg_pkg::axis_strb_w-1:0] lanes;

  // Beat at head and room downstream
  logic can_move;

  assign can_move = !beat_empty && !rec_full;

  // Next state with write and pop strobes
  always_comb begin
    next_state = state;
    beat_rd_en = 1'b0;
    rec_wr_en  = 1'b0;
    src_data   = beat.data;
    src_strb   = beat.strb;

    case (state)
      pcap_rec_pkg::wr_tuser: begin
        // Descriptor is the first beat's tuser zero-extended
        src_data = pcap_rec_pkg::axis_data_t'(beat.tuser);
        src_strb = '1;
        if (can_move) begin
          rec_wr_en = 1'b1;
          // Beat stays at head for the data word
          next_state = pcap_rec_pkg::wr_pkt;
        end
      end
      pcap_rec_pkg::wr_pkt: begin
        if (can_move) begin
          rec_wr_en  = 1'b1;
          beat_rd_en = 1'b1;
          if (beat.last) begin
            next_state = pcap_rec_pkg::wr_tuser;
          end
        end
      end
      default: begin
        next_state = pcap_rec_pkg::wr_tuser;
      end
    endcase
  end

  // Byte plus strobe per lane
  always_comb begin
    for (int i = 0; i < pcap_cfg_pkg::axis_strb_w; i++) begin
      lanes[i].strb = src_strb[i];
      lanes[i].data = src_data[8*i +: 8];
    end
  end

  assign rec_din = lanes;

  // State register
  always_ff @(posedge axi_aclk) begin
    if (!rst_n || sw_rst) begin
      state <= pcap_rec_pkg::wr_tuser;
    end else begin
      state <= next_state;
    end
  end

  // Descriptor write must not consume the beat
  a_no_pop_in_tuser: assert property (@(posedge axi_aclk) disable iff (!rst_n || sw_rst)
    (state == pcap_rec_pkg::wr_tuser) |-> !beat_rd_en);

endmodule

//--- src/record_narrow_fifo.sv
// Record FIFO with a narrowing read port
// Stores 72-bit record words, reads them as 18-bit slices, lowest first
// Read side is first-word-fall-through, rd_en while empty is ignored
`timescale 1ns/1ps

module record_narrow_fifo (
  input  logic                      axi_aclk,
  input  logic                      rst_n,
  input  logic                      sw_rst,
  input  pcap_rec_pkg::rec_word_t   din,
  input  logic                      wr_en,
  output logic                      full,
  input  logic                      rd_en,
  output pcap_rec_pkg::fifo_slice_t dout,
  output logic                      empty
);

  // Word storage
  pcap_rec_pkg::rec_word_t mem [pcap_cfg_pkg::rfifo_depth];

  logic [pcap_cfg_pkg::rfifo_ptr_w-1:0] wr_ptr;
  logic [pcap_cfg_pkg::rfifo_ptr_w-1:0] rd_ptr;
  logic [pcap_cfg_pkg::rfifo_cnt_w-1:0] count;

  // Which slice of the head word is on dout
  logic [pcap_cfg_pkg::slice_idx_w-1:0] slice_idx;

  pcap_rec_pkg::rec_word_t head_word;

  logic do_wr;
  logic do_rd;
  logic word_pop;

  assign full  = (count == pcap_cfg_pkg::rfifo_full_cnt);
  assign empty = (count == '0);

  assign do_wr = wr_en && !full;
  // Slice pop, only with data present
  assign do_rd = rd_en && !empty;
  // Head word leaves after its last slice
  assign word_pop = do_rd && (slice_idx == pcap_cfg_pkg::slice_last);

  // Head slice select
  assign head_word = mem[rd_ptr];
  assign dout      = head_word[slice_idx * pcap_cfg_pkg::slice_w +: pcap_cfg_pkg::slice_w];

  always_ff @(posedge axi_aclk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Write side
  always_ff @(posedge axi_aclk) begin
    if (!rst_n || sw_rst) begin
      wr_ptr <= '0;
    end else if (do_wr) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // Read side, slice counter then word pointer
  always_ff @(posedge axi_aclk) begin
    if (!rst_n || sw_rst) begin
      rd_ptr    <= '0;
      slice_idx <= '0;
    end else if (do_rd) begin
      if (word_pop) begin
        slice_idx <= '0;
        rd_ptr    <= rd_ptr + 1'b1;
      end else begin
        slice_idx <= slice_idx + 1'b1;
      end
    end
  end

  // Occupancy in whole words
  always_ff @(posedge axi_aclk) begin
    if (!rst_n || sw_rst) begin
      count <= '0;
    end else begin
      if (do_wr && !word_pop) begin
        count <= count + 1'b1;
      end else if (word_pop && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // Packer stalls on full, so a write here means lost records
  a_no_wr_full: assert property (@(posedge axi_aclk) disable iff (!rst_n || sw_rst)
    wr_en |-> !full);

  // Slice index only moves while a word is held
  a_idx_idle: assert property (@(posedge axi_aclk) disable iff (!rst_n || sw_rst)
    empty |-> (slice_idx == '0));

endmodule

//--- src/axis_to_fifo.sv
// Capture top level, AXI4-Stream packets in, 18-bit record slices out
// Ingress FIFO feeds the packer, the packer feeds the narrowing FIFO
// sw_rst clears all buffered data like rst_n
`timescale 1ns/1ps

module axis_to_fifo (
  input  logic                      axi_aclk,
  input  logic                      rst_n,
  // AXI4-Stream slave
  input  pcap_rec_pkg::axis_data_t  s_axis_tdata,
  input  pcap_rec_pkg::axis_strb_t  s_axis_tstrb,
  input  pcap_rec_pkg::axis_tuser_t s_axis_tuser,
  input  logic                      s_axis_tvalid,
  output logic                      s_axis_tready,
  input  logic                      s_axis_tlast,
  // Record FIFO read port
  input  logic                      fifo_rd_en,
  output pcap_rec_pkg::fifo_slice_t fifo_dout,
  output logic                      fifo_empty,
  input  logic                      sw_rst
);

  pcap_rec_pkg::axis_beat_t in_beat;
  pcap_rec_pkg::axis_beat_t head_beat;
  pcap_rec_pkg::rec_word_t  rec_din;

  logic ififo_wr_en;
  logic ififo_rd_en;
  logic ififo_empty;
  logic ififo_nearly_full;
  logic rec_wr_en;
  logic rec_full;

  // Bundle the ingress beat
  assign in_beat = '{last: s_axis_tlast, tuser: s_axis_tuser,
                     strb: s_axis_tstrb, data: s_axis_tdata};

  // Back-pressure from the ingress FIFO
  assign s_axis_tready = !ififo_nearly_full;
  assign ififo_wr_en   = s_axis_tvalid && s_axis_tready;

  fallthrough_small_fifo ififo_i (
    .axi_aclk    (axi_aclk),
    .rst_n       (rst_n),
    .sw_rst      (sw_rst),
    .din         (in_beat),
    .wr_en       (ififo_wr_en),
    .rd_en       (ififo_rd_en),
    .dout        (head_beat),
    .empty       (ififo_empty),
    .nearly_full (ififo_nearly_full)
  );

  pcap_record_packer packer_i (
    .axi_aclk   (axi_aclk),
    .rst_n      (rst_n),
    .sw_rst     (sw_rst),
    .beat       (head_beat),
    .beat_empty (ififo_empty),
    .beat_rd_en (ififo_rd_en),
    .rec_full   (rec_full),
    .rec_din    (rec_din),
    .rec_wr_en  (rec_wr_en)
  );

  record_narrow_fifo rfifo_i (
    .axi_aclk (axi_aclk),
    .rst_n    (rst_n),
    .sw_rst   (sw_rst),
    .din      (rec_din),
    .wr_en    (rec_wr_en),
    .full     (rec_full),
    .rd_en    (fifo_rd_en),
    .dout     (fifo_dout),
    .empty    (fifo_empty)
  );

endmodule

//--- dv/pcap_ref_model.svh
// Reference model for the capture path testbench
// Turns accepted AXI4-Stream beats into the queue of expected 18-bit slices
// Included into the testbench module body, also holds the compare tasks
`ifndef PCAP_REF_MODEL_SVH
`define PCAP_REF_MODEL_SVH

  // Expected slices, oldest first
  pcap_rec_pkg::fifo_slice_t exp_q[$];
  // High between the first and the last beat of a packet
  logic in_pkt = 1'b0;

  // Nine bits per byte, strobe bit above the data byte
  function automatic pcap_rec_pkg::rec_word_t make_record(
    input pcap_rec_pkg::axis_data_t data,
    input pcap_rec_pkg::axis_strb_t strb
  );
    pcap_rec_pkg::rec_word_t rec;
    for (int i = 0; i < pcap_cfg_pkg::axis_strb_w; i++) begin
      rec[9*i +: 9] = {strb[i], data[8*i +: 8]};
    end
    return rec;
  endfunction

  // Lowest slice is read first
  task automatic push_record(input pcap_rec_pkg::rec_word_t rec);
    for (int k = 0; k < pcap_cfg_pkg::slices_per_rec; k++) begin
      exp_q.push_back(rec[k*pcap_cfg_pkg::slice_w +: pcap_cfg_pkg::slice_w]);
    end
  endtask

  // One accepted beat, descriptor first when a packet opens
  task automatic model_beat(input pcap_rec_pkg::axis_beat_t b);
    pcap_rec_pkg::axis_data_t desc;
    if (!in_pkt) begin
      // tuser zero-extended, every lane marked valid
      desc = '0;
      desc[pcap_cfg_pkg::axis_tuser_w-1:0] = b.tuser;
      push_record(make_record(desc, '1));
    end
    push_record(make_record(b.data, b.strb));
    in_pkt = !b.last;
  endtask

  // Any reset empties the whole path
  task automatic model_clear();
    exp_q.delete();
    in_pkt = 1'b0;
  endtask

  task automatic check_slice(input pcap_rec_pkg::fifo_slice_t got,
                             input pcap_rec_pkg::fifo_slice_t want);
    if (got !== want) begin
      $display("Fail fifo_dout: got %h, expected %h", got, want);
      stop_run();
    end
  endtask

  task automatic check_ready(input logic got, input logic want);
    if (got !== want) begin
      $display("Fail s_axis_tready: got %h, expected %h", got, want);
      stop_run();
    end
  endtask

  task automatic check_empty(input logic got, input logic want);
    if (got !== want) begin
      $display("Fail fifo_empty: got %h, expected %h", got, want);
      stop_run();
    end
  endtask

`endif

//--- dv/axis_to_fifo_tb.sv
// Testbench for the capture top level
// Random packets in, random slice reads out, every slice checked against a model
// Also covers idle flags, back-pressure, sw_rst mid-packet and reads while empty
`timescale 1ns/1ps

module axis_to_fifo_tb;

  localparam int num_pkts    = 60;
  localparam int max_beats   = 6;
  localparam int wdog_cycles = 200 * num_pkts + 1000;

  logic                      axi_aclk = 1'b0;
  logic                      rst_n;
  pcap_rec_pkg::axis_data_t  s_axis_tdata;
  pcap_rec_pkg::axis_strb_t  s_axis_tstrb;
  pcap_rec_pkg::axis_tuser_t s_axis_tuser;
  logic                      s_axis_tvalid;
  logic                      s_axis_tready;
  logic                      s_axis_tlast;
  logic                      fifo_rd_en = 1'b0;
  pcap_rec_pkg::fifo_slice_t fifo_dout;
  logic                      fifo_empty;
  logic                      sw_rst;

  integer seed = 32'h9c29;
  // Slow reader request, next read decision
  logic stall_rd = 1'b0;
  logic rd_pick  = 1'b0;
  // Monitor bookkeeping
  logic sw_rst_prev   = 1'b0;
  logic saw_ready_low = 1'b0;
  int   empty_reads   = 0;

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  `include "pcap_ref_model.svh"

  axis_to_fifo dut_i (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tstrb  (s_axis_tstrb),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .fifo_rd_en    (fifo_rd_en),
    .fifo_dout     (fifo_dout),
    .fifo_empty    (fifo_empty),
    .sw_rst        (sw_rst)
  );

  always #4 axi_aclk = ~axi_aclk;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  // Nonzero run of contiguous lanes for a closing beat
  function automatic pcap_rec_pkg::axis_strb_t tail_strb();
    int                       len;
    int                       start;
    pcap_rec_pkg::axis_strb_t ones;
    len   = 1 + rand_below(pcap_cfg_pkg::axis_strb_w);
    start = rand_below(pcap_cfg_pkg::axis_strb_w - len + 1);
    ones  = '0;
    for (int i = 0; i < len; i++) begin
      ones[start + i] = 1'b1;
    end
    return ones;
  endfunction

  // Starts on a rising edge, returns on the edge that took the beat
  task automatic drive_beat(input pcap_rec_pkg::axis_data_t  data,
                            input pcap_rec_pkg::axis_strb_t  strb,
                            input pcap_rec_pkg::axis_tuser_t tuser,
                            input logic                      last);
    int   gap;
    logic accepted;
    gap = (rand_below(3) == 0) ? 1 + rand_below(3) : 0;
    if (gap != 0) begin
      s_axis_tvalid <= 1'b0;
      repeat (gap) @(posedge axi_aclk);
    end
    s_axis_tvalid <= 1'b1;
    s_axis_tdata  <= data;
    s_axis_tstrb  <= strb;
    s_axis_tuser  <= tuser;
    s_axis_tlast  <= last;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge axi_aclk);
      accepted = s_axis_tready;
      @(posedge axi_aclk);
    end
  endtask

  // close low leaves the packet open, no tlast
  task automatic send_packet(input int n_beats, input logic close);
    logic [31:0]              r;
    pcap_rec_pkg::axis_strb_t strb;
    logic                     last;
    for (int i = 0; i < n_beats; i++) begin
      last = close && (i == n_beats - 1);
      r    = rand_word();
      strb = last ? tail_strb() : r[pcap_cfg_pkg::axis_strb_w-1:0];
      drive_beat({rand_word(), rand_word()}, strb, {rand_word(), rand_word()}, last);
    end
  endtask

  // Reader draws between edges, ignores fifo_empty on purpose
  always @(negedge axi_aclk) begin
    if (stall_rd) begin
      rd_pick = (rand_below(16) == 0);
    end else begin
      rd_pick = (rand_below(4) != 0);
    end
  end

  always @(posedge axi_aclk) begin
    if (!rst_n) begin
      fifo_rd_en <= 1'b0;
    end else begin
      fifo_rd_en <= rd_pick;
    end
  end

  // Monitor, sampled mid-cycle for what the next edge does
  always @(negedge axi_aclk) begin
    pcap_rec_pkg::axis_beat_t b;
    if (!rst_n) begin
      model_clear();
      sw_rst_prev = 1'b0;
    end else begin
      // Path must be empty right after sw_rst
      if (sw_rst_prev) begin
        check_empty(fifo_empty, 1'b1);
        check_ready(s_axis_tready, 1'b1);
      end
      if (!s_axis_tready) begin
        saw_ready_low = 1'b1;
      end
      if (sw_rst) begin
        model_clear();
      end else begin
        if (fifo_empty && fifo_rd_en) begin
          empty_reads++;
        end
        if (!fifo_empty) begin
          if (exp_q.size() == 0) begin
            $display("DUT shows a slice that the model does not expect");
            stop_run();
          end else begin
            check_slice(fifo_dout, exp_q[0]);
            if (fifo_rd_en) begin
              void'(exp_q.pop_front());
            end
          end
        end
        if (s_axis_tvalid && s_axis_tready) begin
          b = '{last: s_axis_tlast, tuser: s_axis_tuser,
                strb: s_axis_tstrb, data: s_axis_tdata};
          model_beat(b);
        end
      end
      sw_rst_prev = sw_rst;
    end
  end

  initial begin
    repeat (wdog_cycles) @(posedge axi_aclk);
    $display("Timeout after %0d cycles, the run did not complete", wdog_cycles);
    stop_run();
  end

  initial begin
    int n_beats;
    rst_n         = 1'b0;
    sw_rst        = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tstrb  = '0;
    s_axis_tuser  = '0;
    s_axis_tlast  = 1'b0;
    repeat (2) @(posedge axi_aclk);
    rst_n <= 1'b1;
    // Idle flags with no traffic
    repeat (10) begin
      @(negedge axi_aclk);
      check_empty(fifo_empty, 1'b1);
      check_ready(s_axis_tready, 1'b1);
    end
    @(posedge axi_aclk);
    for (int p = 0; p < num_pkts; p++) begin
      if (p == 40) begin
        // Open packet held in the FIFOs, then dropped by sw_rst
        stall_rd <= 1'b1;
        send_packet(5, 1'b0);
        s_axis_tvalid <= 1'b0;
        sw_rst        <= 1'b1;
        @(posedge axi_aclk);
        sw_rst <= 1'b0;
      end
      // Slow reader for a stretch of packets forces back-pressure
      stall_rd <= (p >= 20 && p < 30);
      n_beats = 1 + rand_below(max_beats);
      send_packet(n_beats, 1'b1);
    end
    s_axis_tvalid <= 1'b0;
    stall_rd      <= 1'b0;
    // Drain, then look for stray slices
    while (exp_q.size() != 0) @(posedge axi_aclk);
    repeat (20) @(posedge axi_aclk);
    @(negedge axi_aclk);
    check_empty(fifo_empty, 1'b1);
    if (saw_ready_low && empty_reads > 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("s_axis_tready never dropped or no read was raised while empty");
      stop_run();
    end
  end

endmodule

//--- sim.f
+incdir+dv
src/pcap_cfg_pkg.sv
src/pcap_rec_pkg.sv
src/fallthrough_small_fifo.sv
src/pcap_record_packer.sv
src/record_narrow_fifo.sv
src/axis_to_fifo.sv
dv/axis_to_fifo_tb.sv

//--- Makefile
# Verilator flow for the capture path testbench

TOP := axis_to_fifo_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Some tests failed" sim.log; then \
	  echo "Simulation FAILED, see sim.log"; exit 1; \
	fi
	@grep -q "All tests passed" sim.log || (echo "No pass line in sim.log"; exit 1)

lint:
	verilator --lint-only -Wall --top-module axis_to_fifo \
	  src/pcap_cfg_pkg.sv src/pcap_rec_pkg.sv src/fallthrough_small_fifo.sv \
	  src/pcap_record_packer.sv src/record_narrow_fifo.sv src/axis_to_fifo.sv

clean:
	rm -rf obj_dir sim.log
